/* all.f */
cache_pkg.sv
cache_ctrl.sv
burst_counter.sv
tag_store.sv
data_store.sv
cache_top.sv
tb_clock_gen.sv
cache_tb.sv

/* burst_counter.sv */
`timescale 1ns/100ps
`default_nettype none

module burst_counter (
  input  wire logic                          clk,
  input  wire logic                          reset,
  input  wire logic                          beat_step,
  input  wire logic                          beat_clear,  // clears beat and line
  input  wire logic                          line_step,
  output logic [cache_pkg::offset_bits-1:0]  beat,
  output logic [cache_pkg::index_bits-1:0]   line,
  output logic                               last_beat,
  output logic                               last_line
);
  import cache_pkg::*;

  localparam logic [offset_bits-1:0] beat_max = offset_bits'(words_per_line - 1);
  localparam logic [index_bits-1:0]  line_max = index_bits'(num_lines - 1);

  always_ff @(posedge clk) begin
    if (reset || beat_clear) begin
      beat <= '0;
      line <= '0;
    end else begin
      if (beat_step) begin
        beat <= beat + 1'b1;  // wraps to 0 after the last word
      end
      if (line_step) begin
        line <= line + 1'b1;  // next line of the sweep
      end
    end
  end

  // terminal flags
  assign last_beat = (beat == beat_max);
  assign last_line = (line == line_max);

endmodule

`default_nettype wire

/* cache_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_ctrl (
  input  wire logic            clk,
  input  wire logic            reset,
  input  wire logic            flush_req,      // four-phase flush request
  output logic                 flush_ack,
  input  wire logic            proc_req_val,
  output logic                 proc_req_rdy,
  output logic                 proc_resp_val,
  input  wire logic            proc_resp_rdy,
  output logic                 mem_req_val,
  output logic                 mem_req_write,  // 1 while writing a victim back
  input  wire logic            mem_req_rdy,
  input  wire logic            mem_resp_val,
  output logic                 mem_resp_rdy,
  input  wire logic            req_write,      // captured request is a store
  input  wire logic            hit,
  input  wire logic            victim_dirty,
  input  wire logic            line_valid,
  input  wire logic            last_beat,
  input  wire logic            last_line,
  output logic                 req_capture,    // load the request register
  output logic                 beat_step,
  output logic                 beat_clear,
  output logic                 line_step,
  output logic                 sweep_mode,     // index comes from the sweep counter
  output logic                 tag_write,      // install tag, valid and clean
  output logic                 mark_dirty,
  output logic                 invalidate,
  output logic                 data_we,
  output cache_pkg::data_sel_e data_sel,
  output logic                 data_rd_en
);
  import cache_pkg::*;

  typedef enum logic [2:0] {
    idle, lookup, write_back, refill, merge, respond, flush_scan, flush_ack_wait
  } state_e;

  state_e state_q, state_d;
  logic   phase_q, phase_d;  // beat half: 0 = read/request, 1 = send/response
  logic   sweep_q, sweep_d;  // set for the whole flush

  assign sweep_mode = sweep_q;

  // ====================================================================
  // next state and outputs
  // ====================================================================
  always_comb begin
    state_d       = state_q;
    phase_d       = phase_q;
    sweep_d       = sweep_q;
    flush_ack     = 1'b0;
    proc_req_rdy  = 1'b0;
    proc_resp_val = 1'b0;
    mem_req_val   = 1'b0;
    mem_req_write = 1'b0;
    mem_resp_rdy  = 1'b0;
    req_capture   = 1'b0;
    beat_step     = 1'b0;
    beat_clear    = 1'b0;
    line_step     = 1'b0;
    tag_write     = 1'b0;
    mark_dirty    = 1'b0;
    invalidate    = 1'b0;
    data_we       = 1'b0;
    data_sel      = sel_proc;
    data_rd_en    = 1'b0;
    case (state_q)
      idle: begin
        beat_clear   = 1'b1;                        // beat and sweep line back to 0
        proc_req_rdy = !flush_req;                  // flush wins over a new request
        req_capture  = proc_req_val && !flush_req;
        data_rd_en   = req_capture;                 // read the word in the transfer cycle
        if (flush_req) begin
          state_d = flush_scan;
          sweep_d = 1'b1;
        end else if (proc_req_val) begin
          state_d = lookup;
        end
      end
      lookup: begin
        if (hit) begin
          proc_resp_val = 1'b1;                     // read word is already registered
          data_we       = req_write;                // store hit goes straight in
          mark_dirty    = req_write;
          state_d       = proc_resp_rdy ? idle : respond;
        end else if (line_valid && victim_dirty) begin
          state_d = write_back;
        end else begin
          state_d = refill;
        end
      end
      write_back: begin
        data_sel      = sel_mem;                    // beat counter picks the word
        mem_req_write = 1'b1;
        if (!phase_q) begin
          data_rd_en = 1'b1;                        // fetch the beat word first
          phase_d    = 1'b1;
        end else begin
          mem_req_val = 1'b1;                       // held until memory takes it
          if (mem_req_rdy) begin
            beat_step = 1'b1;
            phase_d   = 1'b0;
            if (last_beat) begin
              if (sweep_q) begin
                invalidate = 1'b1;
                if (last_line) begin
                  state_d = flush_ack_wait;
                end else begin
                  line_step = 1'b1;
                  state_d   = flush_scan;
                end
              end else begin
                state_d = refill;
              end
            end
          end
        end
      end
      refill: begin
        data_sel = sel_mem;
        if (!phase_q) begin
          mem_req_val = 1'b1;                       // read request for this beat
          if (mem_req_rdy) phase_d = 1'b1;
        end else begin
          mem_resp_rdy = 1'b1;
          if (mem_resp_val) begin
            data_we    = 1'b1;
            data_rd_en = 1'b1;                      // data_store keeps the requested word
            beat_step  = 1'b1;
            phase_d    = 1'b0;
            if (last_beat) begin
              tag_write = 1'b1;
              state_d   = req_write ? merge : respond;
            end
          end
        end
      end
      merge: begin
        data_we    = 1'b1;                          // store word over the fresh line
        mark_dirty = 1'b1;
        data_rd_en = 1'b1;
        state_d    = respond;
      end
      respond: begin
        proc_resp_val = 1'b1;
        if (proc_resp_rdy) state_d = idle;
      end
      flush_scan: begin
        if (line_valid && victim_dirty) begin
          state_d = write_back;
        end else begin
          invalidate = 1'b1;                        // clean or empty line
          if (last_line) begin
            state_d = flush_ack_wait;
          end else begin
            line_step = 1'b1;
          end
        end
      end
      flush_ack_wait: begin
        flush_ack = 1'b1;
        if (!flush_req) begin
          state_d = idle;                           // ack drops on the next cycle
          sweep_d = 1'b0;
        end
      end
      default: state_d = idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= idle;
      phase_q <= 1'b0;
      sweep_q <= 1'b0;
    end else begin
      state_q <= state_d;
      phase_q <= phase_d;
      sweep_q <= sweep_d;
    end
  end

  // ====================================================================
  // checks
  // ====================================================================
  a_mem_req_held: assert property (@(posedge clk) disable iff (reset)
    mem_req_val && !mem_req_rdy |=> mem_req_val);

  // victim words stay untouched until the refill waits on its first answer
  a_no_write_in_wb: assert property (@(posedge clk) disable iff (reset)
    state_q == write_back |=> !data_we);

endmodule

`default_nettype wire

/* cache_pkg.sv */
`default_nettype none

package cache_pkg;

  // ====================================================================
  // geometry
  // ====================================================================
  localparam int word_bits      = 32;  // data word width
  localparam int addr_bits      = 12;  // word address width
  localparam int offset_bits    = 2;   // word within a line
  localparam int index_bits     = 4;   // line index
  localparam int tag_bits       = 6;   // upper address bits
  localparam int num_lines      = 16;
  localparam int words_per_line = 4;

  typedef logic [word_bits-1:0] word_t;

  // field view of a word address, msb first
  typedef struct packed {
    logic [tag_bits-1:0]    tag;
    logic [index_bits-1:0]  index;
    logic [offset_bits-1:0] offset;
  } addr_fields_t;

  // one word address, seen raw by memory and split by the arrays
  typedef union packed {
    logic [addr_bits-1:0] raw;
    addr_fields_t         fields;
  } cache_addr_u;

  // ====================================================================
  // port payloads
  // ====================================================================
  typedef struct packed {
    logic        write;  // 1 = store, 0 = load
    cache_addr_u addr;
    word_t       data;   // store data, ignored on a load
  } proc_req_t;

  typedef struct packed {
    word_t data;  // load data
  } proc_resp_t;

  typedef struct packed {
    logic                 write;  // 1 = write-back beat, 0 = refill read
    logic [addr_bits-1:0] addr;
    word_t                data;
  } mem_req_t;

  typedef struct packed {
    word_t data;  // refill word
  } mem_resp_t;

  // source of the data array write port
  typedef enum logic {
    sel_mem  = 1'b0,  // refill word from memory
    sel_proc = 1'b1   // store word from the processor
  } data_sel_e;

endpackage

`default_nettype wire

/* cache_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_tb;
  import cache_pkg::*;

  localparam int limit = 400;  // cycles allowed for any single wait

  typedef enum logic [1:0] {op_read, op_write, op_flush, op_memchk} op_e;

  typedef struct packed {
    op_e                  kind;
    logic [addr_bits-1:0] addr;
    word_t                data;      // store data
    word_t                exp_word;  // load data or memory contents
    logic [7:0]           exp_rd;    // memory reads expected
    logic [7:0]           exp_wr;    // memory writes expected
    logic                 stall;     // random proc_resp_rdy
    logic                 hit_chk;   // response one cycle after transfer
  } op_t;

  logic       clk, reset;
  proc_req_t  proc_req;
  logic       proc_req_val, proc_req_rdy;
  proc_resp_t proc_resp;
  logic       proc_resp_val, proc_resp_rdy;
  mem_req_t   mem_req;
  logic       mem_req_val, mem_req_rdy;
  mem_resp_t  mem_resp;
  logic       mem_resp_val, mem_resp_rdy;
  logic       flush_req, flush_ack;

  word_t                mem [1 << addr_bits];
  logic [addr_bits-1:0] pend_q [$];  // refill reads waiting for an answer
  int                   rd_cnt, wr_cnt, errors;
  logic                 hung;        // a wait ran out of time
  op_t                  ops [$];

  tb_clock_gen clk_i (.clk, .reset);

  cache_top cache_top_i (
    .clk, .reset, .proc_req, .proc_req_val, .proc_req_rdy, .proc_resp, .proc_resp_val,
    .proc_resp_rdy, .mem_req, .mem_req_val, .mem_req_rdy, .mem_resp, .mem_resp_val,
    .mem_resp_rdy, .flush_req, .flush_ack
  );

  function automatic word_t init_word(input logic [addr_bits-1:0] a);
    return {a, 8'h00, a} ^ 32'hc3a5_5a3c;  // every address bit shows up twice
  endfunction

  // ====================================================================
  // behavioral memory
  // ====================================================================
  initial begin
    logic     req_fire, resp_fire;
    mem_req_t req_s;
    int       delay;
    for (int a = 0; a < (1 << addr_bits); a++) mem[a] = init_word(addr_bits'(a));
    mem_req_rdy  = 1'b0;
    mem_resp_val = 1'b0;
    mem_resp     = '0;
    rd_cnt       = 0;
    wr_cnt       = 0;
    delay        = 0;
    forever begin
      @(negedge clk);                             // handshakes are stable here
      req_fire  = mem_req_val && mem_req_rdy;
      req_s     = mem_req;
      resp_fire = mem_resp_val && mem_resp_rdy;
      @(posedge clk);
      #1;
      if (resp_fire) mem_resp_val = 1'b0;
      if (req_fire) begin
        if (req_s.write) begin
          mem[req_s.addr] = req_s.data;
          wr_cnt++;
        end else begin
          pend_q.push_back(req_s.addr);
          rd_cnt++;
        end
      end
      if (!mem_resp_val && pend_q.size() > 0) begin
        if (delay == 0) begin
          mem_resp.data = mem[pend_q.pop_front()];
          mem_resp_val  = 1'b1;
          delay         = int'($urandom_range(3, 0));  // latency of the next answer
        end else begin
          delay--;
        end
      end
      mem_req_rdy = ($urandom_range(3, 0) != 0);      // stall one cycle in four
    end
  end

  // ====================================================================
  // compare tasks
  // ====================================================================
  task automatic check_resp(input proc_resp_t got, input proc_resp_t exp);
    if (got !== exp) begin
      $display("FAILED proc_resp.data got %h expected %h", got.data, exp.data);
      errors++;
    end
  endtask

  task automatic check_traffic(input int got_rd, input int got_wr, input int exp_rd,
                               input int exp_wr);
    if (got_rd != exp_rd || got_wr != exp_wr) begin
      $display("FAILED mem_req reads %h writes %h expected reads %h writes %h",
               got_rd, got_wr, exp_rd, exp_wr);
      errors++;
    end
  endtask

  task automatic check_mem(input logic [addr_bits-1:0] a, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("FAILED mem[%h] got %h expected %h", a, got, exp);
      errors++;
    end
  endtask

  task automatic timed_out(input string what);
    $display("timeout: %s", what);
    hung = 1'b1;
    errors++;
  endtask

  // ====================================================================
  // processor and flush drivers
  // ====================================================================
  task automatic send_req(input logic wr, input logic [addr_bits-1:0] a, input word_t d);
    int   n;
    logic fired;
    n                  = 0;
    fired              = 1'b0;
    proc_req.write     = wr;
    proc_req.addr.raw  = a;
    proc_req.data      = d;
    proc_req_val       = 1'b1;
    while (!fired && !hung) begin
      @(negedge clk);
      n++;
      if (n > limit) begin
        timed_out("processor request never accepted");
      end else begin
        fired = proc_req_rdy;
      end
      @(posedge clk);
      #1;
    end
    proc_req_val = 1'b0;
  endtask

  task automatic wait_resp(input logic stall, output proc_resp_t resp, output int lat);
    proc_resp_t held;
    logic       held_val, done;
    int         n;
    held_val = 1'b0;
    done     = 1'b0;
    n        = 0;
    resp     = '0;
    lat      = 0;
    while (!done && !hung) begin
      @(negedge clk);
      n++;
      if (n > limit) begin
        timed_out("no processor response");
      end else if (proc_resp_val) begin
        if (proc_req_rdy) begin
          $display("cache is ready for a new request while a response waits");
          errors++;
        end
        if (held_val && proc_resp !== held) begin
          $display("FAILED proc_resp.data changed from %h to %h under stall",
                   held.data, proc_resp.data);
          errors++;
        end
        if (proc_resp_rdy) begin
          resp = proc_resp;
          lat  = n;
          done = 1'b1;
        end else begin
          held     = proc_resp;
          held_val = 1'b1;
        end
      end
      @(posedge clk);
      #1;
      proc_resp_rdy = stall ? ($urandom_range(1, 0) == 1) : 1'b1;
    end
    proc_resp_rdy = 1'b1;
  endtask

  task automatic run_flush();
    int n;
    n         = 0;
    flush_req = 1'b1;
    do begin
      @(negedge clk);
      n++;
      if (n > limit) begin
        timed_out("flush_ack never rose");
      end else if (proc_req_rdy) begin
        $display("cache is ready for a request during a flush");
        errors++;
      end
    end while (!flush_ack && !hung);
    @(posedge clk);
    #1;
    flush_req = 1'b0;
    n         = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > limit) timed_out("flush_ack never fell");
    end while (flush_ack && !hung);
    @(posedge clk);
    #1;
  endtask

  task automatic add_op(input op_e k, input int a, input word_t d, input word_t e,
                        input int r, input int w, input logic s, input logic h);
    op_t o;
    o.kind     = k;
    o.addr     = addr_bits'(a);
    o.data     = d;
    o.exp_word = e;
    o.exp_rd   = 8'(r);
    o.exp_wr   = 8'(w);
    o.stall    = s;
    o.hit_chk  = h;
    ops.push_back(o);
  endtask

  // ====================================================================
  // stimulus table and main loop
  // ====================================================================
  initial begin
    op_t        o;
    proc_resp_t resp;
    int         lat, rd0, wr0, err0, failed, n;
    void'($urandom(16));
    proc_req      = '0;
    proc_req_val  = 1'b0;
    proc_resp_rdy = 1'b1;
    flush_req     = 1'b0;
    errors        = 0;
    failed        = 0;
    hung          = 1'b0;

    add_op(op_read,   'h010, '0, init_word(12'h010), 4, 0, 1'b0, 1'b0);  // clean miss
    add_op(op_read,   'h013, '0, init_word(12'h013), 0, 0, 1'b0, 1'b1);  // hit
    add_op(op_write,  'h012, 32'hdead_beef, '0, 0, 0, 1'b0, 1'b0);       // store hit
    add_op(op_read,   'h012, '0, 32'hdead_beef, 0, 0, 1'b0, 1'b1);
    add_op(op_read,   'h412, '0, init_word(12'h412), 4, 4, 1'b0, 1'b0);  // dirty victim
    add_op(op_memchk, 'h012, '0, 32'hdead_beef, 0, 0, 1'b0, 1'b0);
    add_op(op_memchk, 'h011, '0, init_word(12'h011), 0, 0, 1'b0, 1'b0);
    add_op(op_write,  'h0a5, 32'h1234_5678, '0, 4, 0, 1'b0, 1'b0);       // store miss
    add_op(op_read,   'h0a5, '0, 32'h1234_5678, 0, 0, 1'b0, 1'b1);
    add_op(op_write,  'h7f0, 32'hcafe_f00d, '0, 4, 0, 1'b0, 1'b0);
    add_op(op_flush,  'h000, '0, '0, 0, 8, 1'b0, 1'b0);                  // two dirty lines
    add_op(op_memchk, 'h0a5, '0, 32'h1234_5678, 0, 0, 1'b0, 1'b0);
    add_op(op_memchk, 'h7f0, '0, 32'hcafe_f00d, 0, 0, 1'b0, 1'b0);
    add_op(op_memchk, 'h0a4, '0, init_word(12'h0a4), 0, 0, 1'b0, 1'b0);
    add_op(op_read,   'h0a5, '0, 32'h1234_5678, 4, 0, 1'b0, 1'b0);       // flushed line
    add_op(op_read,   'h0a6, '0, init_word(12'h0a6), 0, 0, 1'b1, 1'b0);  // stalled hit
    add_op(op_read,   'h301, '0, init_word(12'h301), 4, 0, 1'b1, 1'b0);  // stalled miss
    add_op(op_write,  'h302, 32'h0bad_f00d, '0, 0, 0, 1'b1, 1'b0);
    add_op(op_read,   'h302, '0, 32'h0bad_f00d, 0, 0, 1'b1, 1'b0);

    n = 0;
    do begin
      @(negedge clk);                             // reset changes after the edge
      n++;
      if (n > limit) timed_out("reset never released");
    end while (reset !== 1'b0 && !hung);
    if (proc_resp_val || mem_req_val || mem_resp_rdy || flush_ack || !proc_req_rdy) begin
      $display("handshake outputs are wrong after reset");
      errors++;
    end
    @(posedge clk);
    #1;

    foreach (ops[i]) begin
      o    = ops[i];
      rd0  = rd_cnt;
      wr0  = wr_cnt;
      err0 = errors;
      proc_resp_rdy = o.stall ? ($urandom_range(1, 0) == 1) : 1'b1;
      case (o.kind)
        op_read, op_write: begin
          send_req(o.kind == op_write, o.addr, o.data);
          wait_resp(o.stall, resp, lat);
          if (o.kind == op_read) check_resp(resp, proc_resp_t'(o.exp_word));
          if (o.hit_chk && lat != 1) begin
            $display("hit response came %0d cycles after the transfer", lat);
            errors++;
          end
          check_traffic(rd_cnt - rd0, wr_cnt - wr0, int'(o.exp_rd), int'(o.exp_wr));
        end
        op_flush: begin
          run_flush();
          check_traffic(rd_cnt - rd0, wr_cnt - wr0, int'(o.exp_rd), int'(o.exp_wr));
        end
        default: check_mem(o.addr, mem[o.addr], o.exp_word);
      endcase
      if (errors != err0) failed++;
      $display("test %0d %s addr %h: %s", i, o.kind.name(), o.addr,
               (errors == err0) ? "ok" : "bad");
      if (hung) break;
    end

    $display("tests %0d, failed %0d, errors %0d", ops.size(), failed, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* cache_top.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_top (
  input  wire logic                    clk,
  input  wire logic                    reset,
  input  wire cache_pkg::proc_req_t    proc_req,
  input  wire logic                    proc_req_val,
  output logic                         proc_req_rdy,
  output cache_pkg::proc_resp_t        proc_resp,
  output logic                         proc_resp_val,
  input  wire logic                    proc_resp_rdy,
  output cache_pkg::mem_req_t          mem_req,
  output logic                         mem_req_val,
  input  wire logic                    mem_req_rdy,
  input  wire cache_pkg::mem_resp_t    mem_resp,
  input  wire logic                    mem_resp_val,
  output logic                         mem_resp_rdy,
  input  wire logic                    flush_req,
  output logic                         flush_ack
);
  import cache_pkg::*;

  proc_req_t              req_q;      // request held for the whole miss
  cache_addr_u            data_addr;
  cache_addr_u            mem_addr;
  word_t                  rd_word;
  logic [offset_bits-1:0] beat;
  logic [index_bits-1:0]  line;
  logic [tag_bits-1:0]    victim_tag;
  data_sel_e              data_sel;
  logic req_capture, beat_step, beat_clear, line_step, sweep_mode;
  logic tag_write, mark_dirty, invalidate, data_we, data_rd_en, mem_req_write;
  logic hit, line_valid, victim_dirty, last_beat, last_line;

  // ====================================================================
  // request register and memory request
  // ====================================================================
  always_ff @(posedge clk) begin
    if (req_capture) req_q <= proc_req;
  end

  // data array reads the incoming address in the transfer cycle
  assign data_addr = req_capture ? proc_req.addr : req_q.addr;

  assign mem_addr.fields.tag    = mem_req_write ? victim_tag : req_q.addr.fields.tag;
  assign mem_addr.fields.index  = sweep_mode ? line : req_q.addr.fields.index;
  assign mem_addr.fields.offset = beat;

  assign mem_req.write  = mem_req_write;
  assign mem_req.addr   = mem_addr.raw;
  assign mem_req.data   = rd_word;        // write-back word, stable while val waits
  assign proc_resp.data = rd_word;

  cache_ctrl ctrl_i (
    .clk, .reset, .flush_req, .flush_ack, .proc_req_val, .proc_req_rdy,
    .proc_resp_val, .proc_resp_rdy, .mem_req_val, .mem_req_write, .mem_req_rdy,
    .mem_resp_val, .mem_resp_rdy, .req_write(req_q.write), .hit, .victim_dirty,
    .line_valid, .last_beat, .last_line, .req_capture, .beat_step, .beat_clear,
    .line_step, .sweep_mode, .tag_write, .mark_dirty, .invalidate, .data_we,
    .data_sel, .data_rd_en
  );

  burst_counter cnt_i (
    .clk, .reset, .beat_step, .beat_clear, .line_step, .beat, .line, .last_beat, .last_line
  );

  tag_store tags_i (
    .clk, .reset, .addr(req_q.addr), .sweep_line(line), .sweep_mode, .tag_write,
    .mark_dirty, .invalidate, .hit, .line_valid, .victim_dirty, .victim_tag
  );

  data_store data_i (
    .clk, .addr(data_addr), .beat, .sweep_line(line), .sweep_mode, .data_sel, .data_we,
    .data_rd_en, .mem_word(mem_resp.data), .proc_word(req_q.data), .rd_word
  );

endmodule

`default_nettype wire

/* data_store.sv */
`timescale 1ns/100ps
`default_nettype none

module data_store (
  input  wire logic                              clk,
  input  wire cache_pkg::cache_addr_u            addr,
  input  wire logic [cache_pkg::offset_bits-1:0] beat,
  input  wire logic [cache_pkg::index_bits-1:0]  sweep_line,
  input  wire logic                              sweep_mode,
  input  wire cache_pkg::data_sel_e              data_sel,   // also picks the offset source
  input  wire logic                              data_we,
  input  wire logic                              data_rd_en,
  input  wire cache_pkg::word_t                  mem_word,
  input  wire cache_pkg::word_t                  proc_word,
  output cache_pkg::word_t                       rd_word
);
  import cache_pkg::*;

  word_t                             data_mem [num_lines*words_per_line];
  logic [index_bits-1:0]             line_idx;
  logic [offset_bits-1:0]            word_off;
  logic [index_bits+offset_bits-1:0] word_idx;
  word_t                             wr_word;
  logic                              rd_load;

  assign line_idx = sweep_mode ? sweep_line : addr.fields.index;
  assign word_off = (data_sel == sel_mem) ? beat : addr.fields.offset;  // memory side walks beats
  assign word_idx = {line_idx, word_off};
  assign wr_word  = (data_sel == sel_mem) ? mem_word : proc_word;

  // a refill beat only loads the read register when it is the requested word
  assign rd_load = data_rd_en &&
                   (!data_we || (data_sel == sel_proc) || (beat == addr.fields.offset));

  always_ff @(posedge clk) begin
    if (data_we) begin
      data_mem[word_idx] <= wr_word;
    end
    if (rd_load) begin
      rd_word <= data_we ? wr_word : data_mem[word_idx];  // write-first
    end
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module cache_tb -o cache_sim \
  > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "verilator build failed"
  exit 1
fi

./obj_dir/cache_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "ERRORS FOUND" sim.log; then
  exit 1
fi
exit 0

/* tag_store.sv */
`timescale 1ns/100ps
`default_nettype none

module tag_store (
  input  wire logic                        clk,
  input  wire logic                        reset,
  input  wire cache_pkg::cache_addr_u      addr,        // captured request address
  input  wire logic [cache_pkg::index_bits-1:0] sweep_line,
  input  wire logic                        sweep_mode,
  input  wire logic                        tag_write,   // refill done
  input  wire logic                        mark_dirty,  // store landed in the line
  input  wire logic                        invalidate,  // flush of one line
  output logic                             hit,
  output logic                             line_valid,
  output logic                             victim_dirty,
  output logic [cache_pkg::tag_bits-1:0]   victim_tag
);
  import cache_pkg::*;

  logic [tag_bits-1:0]   tag_mem [num_lines];
  logic [num_lines-1:0]  valid_q;
  logic [num_lines-1:0]  dirty_q;
  logic [index_bits-1:0] idx;

  // sweep counter owns the index during a flush
  assign idx = sweep_mode ? sweep_line : addr.fields.index;

  assign line_valid   = valid_q[idx];
  assign victim_dirty = valid_q[idx] && dirty_q[idx];  // dirty only counts on a valid line
  assign victim_tag   = tag_mem[idx];
  assign hit          = line_valid && (victim_tag == addr.fields.tag);

  // ====================================================================
  // arrays
  // ====================================================================
  always_ff @(posedge clk) begin
    if (tag_write) begin
      tag_mem[idx] <= addr.fields.tag;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else begin
      if (tag_write) begin
        valid_q[idx] <= 1'b1;  // freshly filled line is clean
        dirty_q[idx] <= 1'b0;
      end
      if (invalidate) begin
        valid_q[idx] <= 1'b0;
        dirty_q[idx] <= 1'b0;
      end
      if (mark_dirty) begin
        dirty_q[idx] <= 1'b1;
      end
    end
  end

  a_tag_write_vs_inval: assert property (@(posedge clk) disable iff (reset)
    !(tag_write && invalidate));

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  initial begin
    reset = 1'b1;
    repeat (5) @(posedge clk);  // 5 cycles of reset
    #1 reset = 1'b0;
  end

endmodule

`default_nettype wire
